// File: vending_machine.f
+incdir+tests
source/vend_money_pkg.sv
source/vend_panel_pkg.sv
source/front_panel.sv
source/stock_table.sv
source/credit_bank.sv
source/status_message.sv
source/vending_machine.sv
tests/tb_vending_machine.sv

// File: Makefile
TOP := tb_vending_machine

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		--top-module $(TOP) -f vending_machine.f -o sim_vending_machine

run: compile
	@out="$$(./obj_dir/sim_vending_machine)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir

// File: tests/vend_tasks.svh
// button codes for press_key
localparam int UP_KEY      = 0;
localparam int DOWN_KEY    = 1;
localparam int SELECT_KEY  = 2;
localparam int BUY_KEY     = 3;
localparam int REFUND_KEY  = 4;
localparam int RESTOCK_KEY = 5;
localparam int ADMIN_KEY   = 6;

//////////////////////////////////////////////////////////////////////
// stimulus and compare helpers
//////////////////////////////////////////////////////////////////////

task automatic wait_cycles(input int cycles);
    repeat (cycles) begin
        @(posedge clk);
        #2;
    end
endtask

task automatic compare(input string name, input int expected, input int actual);
    assert (expected == actual) else begin
        error_count++;
        $display("Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
    end
endtask

// one-cycle pulse, then one more cycle for the state register
task automatic press_key(input int key);
    case (key)
        UP_KEY:      move_up = 1'b1;
        DOWN_KEY:    move_down = 1'b1;
        SELECT_KEY:  select = 1'b1;
        BUY_KEY:     buy = 1'b1;
        REFUND_KEY:  refund = 1'b1;
        RESTOCK_KEY: restock = 1'b1;
        default:     admin = 1'b1;
    endcase
    wait_cycles(1);
    move_up   = 1'b0;
    move_down = 1'b0;
    select    = 1'b0;
    buy       = 1'b0;
    refund    = 1'b0;
    restock   = 1'b0;
    admin     = 1'b0;
    wait_cycles(1);
endtask

task automatic drop_coin(input int units);
    coin = coin_code(units);
    wait_cycles(1);
    coin = '0;
    wait_cycles(1);
    // refused while paying out or past the display limit
    if (!model_refunding && model_credit + units <= int'(CREDIT_MAX)) begin
        model_credit += units;
    end
endtask

task automatic move_cursor(input int key);
    press_key(key);
    // count_shown trails the cursor register
    wait_cycles(1);
    if (key == UP_KEY && model_cursor > 0) begin
        model_cursor--;
    end else if (key == DOWN_KEY && model_cursor < 3) begin
        model_cursor++;
    end
endtask

task automatic select_cursor_item();
    press_key(SELECT_KEY);
    if (model_sel_valid && model_sel_item == model_cursor) begin
        model_sel_valid = 1'b0;
    end else if (model_stock[model_cursor] != 0) begin
        model_sel_valid = 1'b1;
        model_sel_item  = model_cursor;
    end
endtask

task automatic compare_panel();
    compare("credit", model_credit, credit);
    compare("count_shown", model_stock[model_cursor], count_shown);
    compare("selected_valid", model_sel_valid, selected_valid);
    if (model_sel_valid) begin
        compare("selected_item", model_sel_item, selected_item);
    end
endtask

task automatic buy_selected();
    int item;
    int price;
    press_key(BUY_KEY);
    item  = model_sel_item;
    price = price_of(item);
    if (model_sel_valid) begin
        if (model_credit >= price && model_stock[item] != 0) begin
            model_credit -= price;
            model_stock[item]--;
            model_sel_valid = 1'b0;
            compare("message", msg_thanks, message);
        end else if (model_credit < price) begin
            compare("message", msg_no_money, message);
        end
        compare("message_item", item, message_item);
    end
    compare_panel();
endtask

task automatic restock_cursor_item();
    press_key(RESTOCK_KEY);
    if (model_admin && model_stock[model_cursor] < int'(STOCK_MAX)) begin
        model_stock[model_cursor]++;
    end
    compare("count_shown", model_stock[model_cursor], count_shown);
endtask

//////////////////////////////////////////////////////////////////////
// directed tests
//////////////////////////////////////////////////////////////////////

task automatic verify_after_reset();
    compare("credit", 0, credit);
    compare("message", msg_none, message);
    compare("count_shown", 9, count_shown);
    compare("selected_valid", 0, selected_valid);
    compare("refund_valid", 0, refund_valid);
    compare("admin_mode", 0, admin_mode);
endtask

// last step runs into the bottom of the list
task automatic browse_products();
    repeat (4) begin
        move_cursor(DOWN_KEY);
        compare("count_shown", model_stock[model_cursor], count_shown);
    end
endtask

task automatic feed_coins();
    int units [17] = '{10, 5, 1, 10, 10, 10, 10, 10, 10, 10, 10, 10, 5, 1, 1, 1, 1};
    foreach (units[i]) begin
        drop_coin(units[i]);
        compare("credit", model_credit, credit);
    end
endtask

task automatic pay_out_refund();
    int start_credit;
    int start_paid;
    int cycles;
    start_credit    = model_credit;
    start_paid      = paid_units;
    model_refunding = 1'b1;
    press_key(REFUND_KEY);
    compare("refund_valid", 1, refund_valid);
    drop_coin(10);
    cycles = 0;
    while (refund_valid && cycles < REFUND_LIMIT) begin
        wait_cycles(1);
        cycles++;
        if (cycles == 8) begin
            drop_coin(5);
        end
    end
    assert (cycles < REFUND_LIMIT) else begin
        error_count++;
        $display("refund stream still running after %0d cycles", REFUND_LIMIT);
    end
    model_refunding = 1'b0;
    model_credit    = 0;
    compare("refund handshakes", start_credit, paid_units - start_paid);
    compare("credit", 0, credit);
    compare("refund_valid", 0, refund_valid);
endtask

task automatic toggle_selection();
    // empty slot cannot be chosen
    move_cursor(UP_KEY);
    select_cursor_item();
    compare_panel();
    move_cursor(UP_KEY);
    select_cursor_item();
    compare_panel();
    select_cursor_item();
    compare_panel();
endtask

task automatic make_purchases();
    int held;
    move_cursor(DOWN_KEY);
    move_cursor(DOWN_KEY);
    select_cursor_item();
    drop_coin(10);
    drop_coin(5);
    drop_coin(1);
    compare_panel();
    buy_selected();
    repeat (3) begin
        move_cursor(UP_KEY);
    end
    select_cursor_item();
    buy_selected();
    held = 0;
    while (message != msg_none && held <= 2 * HOLD_CYCLES) begin
        wait_cycles(1);
        held++;
    end
    compare("message hold cycles", HOLD_CYCLES, held);
endtask

task automatic restock_in_admin();
    move_cursor(DOWN_KEY);
    move_cursor(DOWN_KEY);
    restock_cursor_item();
    compare("admin_mode", 0, admin_mode);
    press_key(ADMIN_KEY);
    model_admin = 1'b1;
    compare("admin_mode", 1, admin_mode);
    compare("message", msg_admin, message);
    repeat (int'(STOCK_MAX) + 1) begin
        restock_cursor_item();
    end
    press_key(ADMIN_KEY);
    model_admin = 1'b0;
    compare("admin_mode", 0, admin_mode);
endtask

// File: tests/tb_vending_machine.sv
`timescale 1ns/100ps
`default_nettype none

module tb_vending_machine;
    import vend_money_pkg::*;
    import vend_panel_pkg::*;

    localparam int HOLD_CYCLES     = 20;
    localparam int REFUND_LIMIT    = 1000;
    // rough length of the whole sequence, doubled for the watchdog
    localparam int TEST_CYCLES     = 2000;
    localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES;

    logic   clk;
    logic   rst;
    logic   move_up;
    logic   move_down;
    logic   select;
    coin_t  coin;
    logic   buy;
    logic   refund;
    logic   restock;
    logic   admin;
    logic   refund_ready;
    money_t credit;
    count_t count_shown;
    logic   selected_valid;
    item_t  selected_item;
    logic   refund_valid;
    msg_t   message;
    item_t  message_item;
    logic   admin_mode;

    int          error_count = 0;
    int          paid_units = 0;
    logic        prev_valid = 1'b0;
    logic        prev_ready = 1'b0;
    logic [31:0] rng_state;

    // reference model of credit, stock and panel
    int   model_credit;
    int   model_stock [4];
    int   model_cursor;
    logic model_sel_valid;
    int   model_sel_item;
    logic model_admin;
    logic model_refunding;

    vending_machine #(
        .MSG_HOLD(HOLD_CYCLES)
    ) vending_machine_inst (
        .clk(clk), .rst(rst),
        .move_up(move_up), .move_down(move_down), .select(select), .coin(coin),
        .buy(buy), .refund(refund), .restock(restock), .admin(admin),
        .refund_ready(refund_ready), .credit(credit), .count_shown(count_shown),
        .selected_valid(selected_valid), .selected_item(selected_item),
        .refund_valid(refund_valid), .message(message), .message_item(message_item),
        .admin_mode(admin_mode)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // price list in 100 won units
    function automatic int price_of(input int item);
        case (item)
            0:       return 10;
            1:       return 12;
            2:       return 15;
            default: return 18;
        endcase
    endfunction

    // top bit one unit, middle five, low ten
    function automatic coin_t coin_code(input int units);
        case (units)
            1:       return 3'b100;
            5:       return 3'b010;
            default: return 3'b001;
        endcase
    endfunction

    `include "vend_tasks.svh"

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // coin hopper
    //////////////////////////////////////////////////////////////////////

    initial begin : hopper
        refund_ready = 1'b0;
        rng_state    = 32'h4c6;
        forever begin
            @(posedge clk);
            #2;
            rng_state    = xorshift32(rng_state);
            refund_ready = rng_state[0];
        end
    end

    // handshakes counted mid-cycle where both sides are stable
    always @(negedge clk) begin
        if (rst) begin
            if (refund_valid && refund_ready) begin
                paid_units++;
            end
            assert (!(prev_valid && !prev_ready && !refund_valid)) else begin
                error_count++;
                $display("refund_valid fell at %0t while the hopper held it off", $time);
            end
        end
        prev_valid = refund_valid;
        prev_ready = refund_ready;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("run stopped by the watchdog after %0d cycles", WATCHDOG_CYCLES);
        $display("Errors: %0d", error_count);
        $display("Testbench failed");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin : run_tests
        rst       = 1'b0;
        move_up   = 1'b0;
        move_down = 1'b0;
        select    = 1'b0;
        coin      = '0;
        buy       = 1'b0;
        refund    = 1'b0;
        restock   = 1'b0;
        admin     = 1'b0;
        model_credit    = 0;
        model_stock     = '{9, 1, 0, 4};
        model_cursor    = 0;
        model_sel_valid = 1'b0;
        model_sel_item  = 0;
        model_admin     = 1'b0;
        model_refunding = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b1;
        verify_after_reset();
        browse_products();
        feed_coins();
        pay_out_refund();
        toggle_selection();
        make_purchases();
        restock_in_admin();
        $display("Errors: %0d", error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/vending_machine.sv
`timescale 1ns/100ps
`default_nettype none

module vending_machine #(
    parameter int MSG_HOLD = 1000000
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   move_up,
    input  logic                   move_down,
    input  logic                   select,
    input  vend_panel_pkg::coin_t  coin,
    input  logic                   buy,
    input  logic                   refund,
    input  logic                   restock,
    input  logic                   admin,
    input  logic                   refund_ready,
    output vend_money_pkg::money_t credit,
    output vend_money_pkg::count_t count_shown,
    output logic                   selected_valid,
    output vend_money_pkg::item_t  selected_item,
    output logic                   refund_valid,
    output vend_panel_pkg::msg_t   message,
    output vend_money_pkg::item_t  message_item,
    output logic                   admin_mode
);
    import vend_money_pkg::*;
    import vend_panel_pkg::*;

    // panel to the other blocks
    item_t  cursor;
    logic   coin_cmd;
    money_t coin_amount;
    logic   buy_cmd;
    logic   refund_cmd;
    logic   restock_cmd;
    logic   admin_cmd;

    // stock and credit links
    logic   cursor_in_stock;
    logic   selected_in_stock;
    logic   vend;
    logic   purchase_done;

    // toward the status line
    logic   msg_set;
    msg_t   msg_code;
    item_t  msg_item;
    logic   admin_on_pulse;

    //////////////////////////////////////////////////////////////////////
    // blocks
    //////////////////////////////////////////////////////////////////////

    front_panel front_panel_inst (
        .clk(clk), .rst(rst),
        .move_up(move_up), .move_down(move_down), .select(select),
        .buy(buy), .refund(refund), .restock(restock), .admin(admin), .coin(coin),
        .purchase_done(purchase_done), .cursor_in_stock(cursor_in_stock),
        .cursor(cursor), .selected_valid(selected_valid), .selected_item(selected_item),
        .coin_cmd(coin_cmd), .coin_amount(coin_amount), .buy_cmd(buy_cmd),
        .refund_cmd(refund_cmd), .restock_cmd(restock_cmd), .admin_cmd(admin_cmd)
    );

    stock_table stock_table_inst (
        .clk(clk), .rst(rst),
        .cursor(cursor), .selected_item(selected_item),
        .vend(vend), .restock_cmd(restock_cmd), .admin_cmd(admin_cmd),
        .cursor_count(count_shown), .cursor_in_stock(cursor_in_stock),
        .selected_in_stock(selected_in_stock), .admin_mode(admin_mode),
        .admin_on_pulse(admin_on_pulse)
    );

    credit_bank credit_bank_inst (
        .clk(clk), .rst(rst),
        .coin_cmd(coin_cmd), .buy_cmd(buy_cmd), .refund_cmd(refund_cmd),
        .coin_amount(coin_amount), .selected_valid(selected_valid),
        .selected_item(selected_item), .selected_in_stock(selected_in_stock),
        .refund_ready(refund_ready), .credit(credit), .refund_valid(refund_valid),
        .vend(vend), .purchase_done(purchase_done),
        .msg_set(msg_set), .msg_code(msg_code), .msg_item(msg_item)
    );

    status_message #(
        .MSG_HOLD(MSG_HOLD)
    ) status_message_inst (
        .clk(clk), .rst(rst),
        .msg_set(msg_set), .msg_code(msg_code), .msg_item(msg_item),
        .admin_on_pulse(admin_on_pulse),
        .message(message), .message_item(message_item)
    );

endmodule

`default_nettype wire

// File: source/status_message.sv
`timescale 1ns/100ps
`default_nettype none

module status_message #(
    parameter int MSG_HOLD = 1000000
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  msg_set,
    input  vend_panel_pkg::msg_t  msg_code,
    input  vend_money_pkg::item_t msg_item,
    input  logic                  admin_on_pulse,
    output vend_panel_pkg::msg_t  message,
    output vend_money_pkg::item_t message_item
);
    import vend_panel_pkg::*;

    localparam int HOLD_W = $clog2(MSG_HOLD + 1);
    localparam logic [HOLD_W-1:0] HOLD_LOAD = HOLD_W'(MSG_HOLD - 1);

    logic [HOLD_W-1:0] hold_count;

    //////////////////////////////////////////////////////////////////////
    // message and hold timer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            message    <= msg_none;
            hold_count <= '0;
        end else if (msg_set) begin
            // purchase result beats the admin notice
            message    <= msg_code;
            hold_count <= HOLD_LOAD;
        end else if (admin_on_pulse) begin
            message    <= msg_admin;
            hold_count <= HOLD_LOAD;
        end else if (message != msg_none) begin
            if (hold_count == '0) begin
                message <= msg_none;
            end else begin
                hold_count <= hold_count - 1'b1;
            end
        end
    end

    // product shown with thanks and no-money
    always_ff @(posedge clk) begin
        if (msg_set) begin
            message_item <= msg_item;
        end
    end

endmodule

`default_nettype wire

// File: source/credit_bank.sv
`timescale 1ns/100ps
`default_nettype none

module credit_bank (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   coin_cmd,
    input  logic                   buy_cmd,
    input  logic                   refund_cmd,
    input  vend_money_pkg::money_t coin_amount,
    input  logic                   selected_valid,
    input  vend_money_pkg::item_t  selected_item,
    input  logic                   selected_in_stock,
    input  logic                   refund_ready,
    output vend_money_pkg::money_t credit,
    output logic                   refund_valid,
    output logic                   vend,
    output logic                   purchase_done,
    output logic                   msg_set,
    output vend_panel_pkg::msg_t   msg_code,
    output vend_money_pkg::item_t  msg_item
);
    import vend_money_pkg::*;
    import vend_panel_pkg::*;

    money_t price;
    money_t coin_sum;
    logic   coin_ok;
    logic   buy_go;
    logic   buy_ok;
    logic   buy_short;
    logic   pay_unit;

    //////////////////////////////////////////////////////////////////////
    // coin and purchase decisions
    //////////////////////////////////////////////////////////////////////

    assign price    = PRICE[selected_item];
    assign coin_sum = credit + coin_amount;

    // no coins while paying out, none past the display limit
    assign coin_ok = coin_cmd && !refund_valid && (coin_sum <= CREDIT_MAX);

    // buying waits until the payout has finished
    assign buy_go    = buy_cmd && selected_valid && !refund_valid;
    assign buy_ok    = buy_go && selected_in_stock && (credit >= price);
    assign buy_short = buy_go && (credit < price);

    // one unit leaves the hopper per handshake
    assign pay_unit = refund_valid && refund_ready;

    assign vend          = buy_ok;
    assign purchase_done = buy_ok;

    // status toward the message register
    assign msg_set  = buy_ok || buy_short;
    assign msg_code = buy_ok ? msg_thanks : msg_no_money;
    assign msg_item = selected_item;

    //////////////////////////////////////////////////////////////////////
    // credit register
    //////////////////////////////////////////////////////////////////////

    // the three sources never overlap
    always_ff @(posedge clk) begin
        if (!rst) begin
            credit <= '0;
        end else if (coin_ok) begin
            credit <= coin_sum;
        end else if (buy_ok) begin
            credit <= credit - price;
        end else if (pay_unit) begin
            credit <= credit - 8'd1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // refund stream
    //////////////////////////////////////////////////////////////////////

    // valid holds through back-pressure and drops with the last unit
    always_ff @(posedge clk) begin
        if (!rst) begin
            refund_valid <= 1'b0;
        end else if (pay_unit && credit == 8'd1) begin
            refund_valid <= 1'b0;
        end else if (refund_cmd && credit != '0) begin
            refund_valid <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: source/stock_table.sv
`timescale 1ns/100ps
`default_nettype none

module stock_table (
    input  logic                   clk,
    input  logic                   rst,
    input  vend_money_pkg::item_t  cursor,
    input  vend_money_pkg::item_t  selected_item,
    input  logic                   vend,
    input  logic                   restock_cmd,
    input  logic                   admin_cmd,
    output vend_money_pkg::count_t cursor_count,
    output logic                   cursor_in_stock,
    output logic                   selected_in_stock,
    output logic                   admin_mode,
    output logic                   admin_on_pulse
);
    import vend_money_pkg::*;

    count_t stock [4];
    count_t stock_next [4];
    logic   restock_hit;

    //////////////////////////////////////////////////////////////////////
    // availability flags
    //////////////////////////////////////////////////////////////////////

    assign cursor_in_stock   = (stock[cursor] != '0);
    assign selected_in_stock = (stock[selected_item] != '0);

    // only the off to on transition raises the message
    assign admin_on_pulse = admin_cmd && !admin_mode;

    // restock works in admin mode only, capped at STOCK_MAX
    assign restock_hit = restock_cmd && admin_mode && (stock[cursor] < STOCK_MAX);

    //////////////////////////////////////////////////////////////////////
    // next counts
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        stock_next = stock;
        if (vend) begin
            stock_next[selected_item] = stock[selected_item] - 4'd1;
        end
        if (restock_hit) begin
            stock_next[cursor] = stock[cursor] + 4'd1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // count registers and admin flag
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            stock        <= INIT_STOCK;
            cursor_count <= INIT_STOCK[0];
            admin_mode   <= 1'b0;
        end else begin
            stock <= stock_next;

            // follow the new count so a vend or restock shows at once
            // while a cursor move takes one more cycle
            cursor_count <= stock_next[cursor];

            if (admin_cmd) begin
                admin_mode <= !admin_mode;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/front_panel.sv
`timescale 1ns/100ps
`default_nettype none

module front_panel (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   move_up,
    input  logic                   move_down,
    input  logic                   select,
    input  logic                   buy,
    input  logic                   refund,
    input  logic                   restock,
    input  logic                   admin,
    input  vend_panel_pkg::coin_t  coin,
    input  logic                   purchase_done,
    input  logic                   cursor_in_stock,
    output vend_money_pkg::item_t  cursor,
    output logic                   selected_valid,
    output vend_money_pkg::item_t  selected_item,
    output logic                   coin_cmd,
    output vend_money_pkg::money_t coin_amount,
    output logic                   buy_cmd,
    output logic                   refund_cmd,
    output logic                   restock_cmd,
    output logic                   admin_cmd
);
    import vend_money_pkg::*;
    import vend_panel_pkg::*;

    localparam item_t LAST_ITEM = 2'd3;

    logic   up_cmd;
    logic   down_cmd;
    logic   select_cmd;
    money_t coin_value;

    // coin code to 100 won units
    always_comb begin
        case (coin)
            COIN_ONE:  coin_value = 8'd1;
            COIN_FIVE: coin_value = 8'd5;
            COIN_TEN:  coin_value = 8'd10;
            default:   coin_value = 8'd0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // command stage
    //////////////////////////////////////////////////////////////////////

    // one button per cycle, earlier in the chain wins
    always_ff @(posedge clk) begin
        if (!rst) begin
            up_cmd      <= 1'b0;
            down_cmd    <= 1'b0;
            select_cmd  <= 1'b0;
            coin_cmd    <= 1'b0;
            buy_cmd     <= 1'b0;
            refund_cmd  <= 1'b0;
            restock_cmd <= 1'b0;
            admin_cmd   <= 1'b0;
        end else begin
            up_cmd      <= move_up;
            down_cmd    <= !move_up && move_down;
            select_cmd  <= !move_up && !move_down && select;
            coin_cmd    <= !move_up && !move_down && !select && (coin_value != '0);
            buy_cmd     <= !move_up && !move_down && !select && (coin_value == '0) && buy;
            refund_cmd  <= !move_up && !move_down && !select && (coin_value == '0) && !buy
                           && refund;
            restock_cmd <= !move_up && !move_down && !select && (coin_value == '0) && !buy
                           && !refund && restock;
            admin_cmd   <= !move_up && !move_down && !select && (coin_value == '0) && !buy
                           && !refund && !restock && admin;
        end
    end

    // amount only matters while coin_cmd is high
    always_ff @(posedge clk) begin
        coin_amount <= coin_value;
    end

    //////////////////////////////////////////////////////////////////////
    // cursor and selection
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            cursor         <= '0;
            selected_valid <= 1'b0;
            selected_item  <= '0;
        end else begin
            // saturate at both ends of the list
            if (up_cmd && cursor != '0) begin
                cursor <= cursor - 2'd1;
            end else if (down_cmd && cursor != LAST_ITEM) begin
                cursor <= cursor + 2'd1;
            end

            if (purchase_done) begin
                selected_valid <= 1'b0;
            end else if (select_cmd) begin
                // second press on the same item drops it
                if (selected_valid && selected_item == cursor) begin
                    selected_valid <= 1'b0;
                end else if (cursor_in_stock) begin
                    selected_valid <= 1'b1;
                    selected_item  <= cursor;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/vend_panel_pkg.sv
`default_nettype none

package vend_panel_pkg;

    //////////////////////////////////////////////////////////////////////
    // coin switches
    //////////////////////////////////////////////////////////////////////

    // one-hot code from the three coin buttons
    typedef logic [2:0] coin_t;

    // 100 won
    localparam coin_t COIN_ONE = 3'b100;
    // 500 won
    localparam coin_t COIN_FIVE = 3'b010;
    // 1000 won
    localparam coin_t COIN_TEN = 3'b001;

    //////////////////////////////////////////////////////////////////////
    // status line
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        msg_none,
        msg_thanks,
        msg_no_money,
        msg_admin
    } msg_t;

endpackage

`default_nettype wire

// File: source/vend_money_pkg.sv
`default_nettype none

package vend_money_pkg;

    //////////////////////////////////////////////////////////////////////
    // money and product widths
    //////////////////////////////////////////////////////////////////////

    // credit counted in 100 won units
    typedef logic [7:0] money_t;

    // product number 0 to 3
    typedef logic [1:0] item_t;

    // units left in one product slot
    typedef logic [3:0] count_t;

    //////////////////////////////////////////////////////////////////////
    // price list and stock limits
    //////////////////////////////////////////////////////////////////////

    // restock stops here
    localparam count_t STOCK_MAX = 4'd9;

    // coke, water, juice, cider
    localparam money_t PRICE [4] = '{8'd10, 8'd12, 8'd15, 8'd18};

    // slot contents after reset
    localparam count_t INIT_STOCK [4] = '{4'd9, 4'd1, 4'd0, 4'd4};

    // highest credit the money display can show
    localparam money_t CREDIT_MAX = 8'd99;

endpackage

`default_nettype wire
